// File: project.f
design/rv_decode_pkg.sv
design/rv_imm_gen.sv
design/rv_pc_cir_ctrl.sv
design/rv_instr_decode.sv
design/rv_decode.sv
bench/tb_rv_decode.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_rv_decode -f project.f -o tb_rv_decode \
	|| { echo "build failed"; exit 1; }

out="$(./obj_dir/tb_rv_decode)" || { echo "$out"; echo "simulation exited with an error"; exit 1; }
echo "$out"
grep -qx "all tests passed" <<< "$out" && exit 0 || exit 1

// File: bench/tb_rv_decode.sv
// Inputs change on the falling edge; PC, lock and CIR use are checked against a stall and jump model
module tb_rv_decode;
	timeunit 1ns;
	timeprecision 1ns;

	logic                          clk;
	logic                          rst_n;
	logic [31:0]                   fd_cir_i;
	logic [1:0]                    fd_cir_vld_i;
	logic [1:0]                    fd_cir_err_i;
	logic                          x_stall_i;
	logic                          f_jump_now_i;
	logic [31:0]                   f_jump_target_i;
	logic                          x_jump_not_except_i;
	logic [1:0]                    df_cir_use_o;
	logic                          df_cir_lock_o;
	logic [31:0]                   d_pc_o;
	logic                          d_starved_o;
	logic [4:0]                    d_rs1_o;
	logic [4:0]                    d_rs2_o;
	logic [4:0]                    d_rd_o;
	logic [31:0]                   d_imm_o;
	rv_decode_pkg::alusrc_a_t      d_alusrc_a_o;
	rv_decode_pkg::alusrc_b_t      d_alusrc_b_o;
	rv_decode_pkg::aluop_t         d_aluop_o;
	rv_decode_pkg::memop_t         d_memop_o;
	rv_decode_pkg::bcond_t         d_branchcond_o;
	logic                          d_addr_is_regoffs_o;
	rv_decode_pkg::except_t        d_except_o;
	logic [31:0]                   d_addr_offs_o;

	logic [31:0] rng_state;
	logic [31:0] model_pc;
	logic        lock_held;
	int          errors;

	rv_decode u_rv_decode (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Helpers and reference rules
	// ------------------------------------------------------------------

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [31:0] sign_extend(input logic [31:0] value, input int width);
		logic [31:0] shifted;
		shifted = value << (32 - width);
		return $signed(shifted) >>> (32 - width);
	endfunction

	// RV32I funct3 table where alt selects the funct7 bit 5 variant
	function automatic rv_decode_pkg::aluop_t expected_aluop(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? rv_decode_pkg::ALUOP_SUB : rv_decode_pkg::ALUOP_ADD;
			3'd1:    return rv_decode_pkg::ALUOP_SLL;
			3'd2:    return rv_decode_pkg::ALUOP_LT;
			3'd3:    return rv_decode_pkg::ALUOP_LTU;
			3'd4:    return rv_decode_pkg::ALUOP_XOR;
			3'd5:    return alt ? rv_decode_pkg::ALUOP_SRA : rv_decode_pkg::ALUOP_SRL;
			3'd6:    return rv_decode_pkg::ALUOP_OR;
			default: return rv_decode_pkg::ALUOP_AND;
		endcase
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_stage_state();
		logic starved;
		logic stalled;
		logic exp_lock;
		starved  = fd_cir_vld_i < 2'd2;
		stalled  = x_stall_i || starved;
		exp_lock = (lock_held && stalled) || (f_jump_now_i && x_jump_not_except_i && stalled);
		check_eq("d_pc_o", d_pc_o, model_pc);
		check_eq("d_starved_o", 32'(d_starved_o), 32'(starved));
		check_eq("df_cir_lock_o", 32'(df_cir_lock_o), 32'(exp_lock));
		check_eq("df_cir_use_o", 32'(df_cir_use_o), stalled ? 32'd0 : 32'd2);
	endtask

	task automatic drive(input logic [31:0] instr, input logic [1:0] vld, input logic [1:0] err,
		input logic stall, input logic jump, input logic [31:0] target);
		fd_cir_i            = instr;
		fd_cir_vld_i        = vld;
		fd_cir_err_i        = err;
		x_stall_i           = stall;
		f_jump_now_i        = jump;
		x_jump_not_except_i = jump;
		f_jump_target_i     = target;
		#1;
		check_stage_state();
	endtask

	// Advance the PC and lock model over the next rising edge
	task automatic step();
		logic stalled;
		logic setting;
		stalled = x_stall_i || fd_cir_vld_i < 2'd2;
		setting = f_jump_now_i && x_jump_not_except_i && stalled;
		if (!rst_n) begin
			model_pc  = rv_decode_pkg::RESET_VECTOR;
			lock_held = 1'b0;
		end else begin
			if ((f_jump_now_i && !setting) || (lock_held && !stalled)) begin
				model_pc = f_jump_target_i;
			end else if (!stalled && !lock_held && !setting) begin
				model_pc = model_pc + 32'd4;
			end
			lock_held = (lock_held && stalled) || setting;
		end
		@(negedge clk);
	endtask

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------

	initial begin : main
		logic [31:0]            r;
		logic [31:0]            instr;
		logic [31:0]            exp_offs;
		logic [31:0]            target;
		logic [2:0]             f3;
		logic                   alt;
		logic                   is_imm;
		logic                   exp_regoffs;
		logic [4:0]             exp_rd;
		logic [4:0]             exp_rs2;
		rv_decode_pkg::memop_t  exp_mem;
		rv_decode_pkg::bcond_t  exp_bc;
		rv_decode_pkg::aluop_t  exp_alu;
		rv_decode_pkg::except_t exp_exc;
		int                     hold;

		rng_state = 32'h7dfe36c2;
		errors    = 0;
		model_pc  = rv_decode_pkg::RESET_VECTOR;
		lock_held = 1'b0;
		rst_n               = 1'b0;
		fd_cir_i            = 32'h0000_0013;
		fd_cir_vld_i        = 2'd2;
		fd_cir_err_i        = 2'd0;
		x_stall_i           = 1'b0;
		f_jump_now_i        = 1'b0;
		f_jump_target_i     = 32'h0;
		x_jump_not_except_i = 1'b0;
		@(negedge clk);

		// Reset, PC pinned and no lock
		for (int i = 0; i < 16; i++) begin
			drive(32'h0000_0013, 2'd2, 2'd0, 1'b0, 1'b0, 32'h0);
			step();
		end
		rst_n = 1'b1;

		// ALU encodings
		for (int i = 0; i < 60; i++) begin
			r     = next_random();
			instr = next_random();
			case (r[1:0])
				2'd0: begin
					f3         = 3'b000;
					alt        = 1'b0;
					instr[6:0] = 7'h13;
				end
				2'd1: begin
					f3            = r[2] ? 3'b101 : 3'b001;
					alt           = r[2] & r[3];
					instr[31:25]  = alt ? 7'h20 : 7'h00;
					instr[6:0]    = 7'h13;
				end
				default: begin
					f3            = r[6:4];
					alt           = (f3 == 3'd0 || f3 == 3'd5) && r[3];
					instr[31:25]  = alt ? 7'h20 : 7'h00;
					instr[6:0]    = 7'h33;
				end
			endcase
			instr[14:12] = f3;
			is_imm       = !instr[5];
			drive(instr, 2'd2, 2'd0, 1'b0, 1'b0, 32'h0);
			check_eq("d_aluop_o", 32'(d_aluop_o), 32'(expected_aluop(f3, alt)));
			check_eq("d_alusrc_a_o", 32'(d_alusrc_a_o), 32'(rv_decode_pkg::ALUSRCA_RS1));
			check_eq("d_alusrc_b_o", 32'(d_alusrc_b_o), is_imm ?
				32'(rv_decode_pkg::ALUSRCB_IMM) : 32'(rv_decode_pkg::ALUSRCB_RS2));
			if (is_imm) begin
				check_eq("d_imm_o", d_imm_o, sign_extend(32'(instr[31:20]), 12));
			end
			check_eq("d_rs1_o", 32'(d_rs1_o), 32'(instr[19:15]));
			check_eq("d_rs2_o", 32'(d_rs2_o), is_imm ? 32'd0 : 32'(instr[24:20]));
			check_eq("d_rd_o", 32'(d_rd_o), 32'(instr[11:7]));
			check_eq("d_except_o", 32'(d_except_o), 32'(rv_decode_pkg::EXCEPT_NONE));
			step();
		end

		// Loads, stores, branches and jumps
		for (int i = 0; i < 80; i++) begin
			r           = next_random();
			instr       = next_random();
			exp_mem     = rv_decode_pkg::MEMOP_NONE;
			exp_bc      = rv_decode_pkg::BCOND_NEVER;
			exp_alu     = rv_decode_pkg::ALUOP_ADD;
			exp_regoffs = 1'b0;
			exp_rd      = instr[11:7];
			exp_rs2     = instr[24:20];
			case (r[2:0])
				3'd0, 3'd5: begin
					f3 = r[5:3];
					if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd0;
					instr[14:12] = f3;
					instr[6:0]   = 7'h03;
					case (f3)
						3'd0:    exp_mem = rv_decode_pkg::MEMOP_LB;
						3'd1:    exp_mem = rv_decode_pkg::MEMOP_LH;
						3'd2:    exp_mem = rv_decode_pkg::MEMOP_LW;
						3'd4:    exp_mem = rv_decode_pkg::MEMOP_LBU;
						default: exp_mem = rv_decode_pkg::MEMOP_LHU;
					endcase
					exp_offs    = sign_extend(32'(instr[31:20]), 12);
					exp_rs2     = 5'd0;
					exp_regoffs = 1'b1;
				end
				3'd1: begin
					f3           = (r[4:3] == 2'd3) ? 3'd0 : {1'b0, r[4:3]};
					instr[14:12] = f3;
					instr[6:0]   = 7'h23;
					exp_mem      = (f3 == 3'd0) ? rv_decode_pkg::MEMOP_SB :
						(f3 == 3'd1) ? rv_decode_pkg::MEMOP_SH : rv_decode_pkg::MEMOP_SW;
					exp_alu      = rv_decode_pkg::ALUOP_RS2;
					exp_rd       = 5'd0;
					exp_regoffs  = 1'b1;
					exp_offs     = sign_extend(32'({instr[31:25], instr[11:7]}), 12);
				end
				3'd2, 3'd6: begin
					f3 = r[5:3];
					if (f3[2:1] == 2'b01) f3[1] = 1'b0;
					instr[14:12] = f3;
					instr[6:0]   = 7'h63;
					// BEQ, BGE and BGEU branch when the ALU result is zero
					exp_bc  = (f3 == 3'd0 || f3 == 3'd5 || f3 == 3'd7) ?
						rv_decode_pkg::BCOND_ZERO : rv_decode_pkg::BCOND_NZERO;
					exp_alu = !f3[2] ? rv_decode_pkg::ALUOP_SUB :
						!f3[1] ? rv_decode_pkg::ALUOP_LT : rv_decode_pkg::ALUOP_LTU;
					exp_rd  = 5'd0;
					exp_offs = sign_extend(32'({instr[31], instr[7], instr[30:25],
						instr[11:8], 1'b0}), 13);
				end
				3'd3: begin
					instr[6:0] = 7'h6f;
					exp_bc     = rv_decode_pkg::BCOND_ALWAYS;
					exp_rs2    = 5'd0;
					exp_offs   = sign_extend(32'({instr[31], instr[19:12], instr[20],
						instr[30:21], 1'b0}), 21);
				end
				default: begin
					// JALR targets rs1 plus the I offset
					instr[14:12] = 3'd0;
					instr[6:0]   = 7'h67;
					exp_bc       = rv_decode_pkg::BCOND_ALWAYS;
					exp_rs2      = 5'd0;
					exp_regoffs  = 1'b1;
					exp_offs     = sign_extend(32'(instr[31:20]), 12);
				end
			endcase
			drive(instr, 2'd2, 2'd0, 1'b0, 1'b0, 32'h0);
			check_eq("d_memop_o", 32'(d_memop_o), 32'(exp_mem));
			check_eq("d_branchcond_o", 32'(d_branchcond_o), 32'(exp_bc));
			check_eq("d_aluop_o", 32'(d_aluop_o), 32'(exp_alu));
			check_eq("d_addr_offs_o", d_addr_offs_o, exp_offs);
			check_eq("d_addr_is_regoffs_o", 32'(d_addr_is_regoffs_o), 32'(exp_regoffs));
			check_eq("d_rd_o", 32'(d_rd_o), 32'(exp_rd));
			check_eq("d_rs2_o", 32'(d_rs2_o), 32'(exp_rs2));
			check_eq("d_except_o", 32'(d_except_o), 32'(rv_decode_pkg::EXCEPT_NONE));
			if (exp_bc == rv_decode_pkg::BCOND_ALWAYS) begin
				check_eq("d_imm_o", d_imm_o, 32'd4);
				check_eq("d_alusrc_a_o", 32'(d_alusrc_a_o), 32'(rv_decode_pkg::ALUSRCA_PC));
			end else begin
				check_eq("d_alusrc_a_o", 32'(d_alusrc_a_o), 32'(rv_decode_pkg::ALUSRCA_RS1));
			end
			step();
		end

		// Bus faults, undefined opcodes and a starved CIR
		for (int i = 0; i < 40; i++) begin
			r            = next_random();
			instr        = next_random();
			instr[31:25] = 7'h00;
			instr[14:12] = 3'd0;
			instr[6:0]   = 7'h33;
			case (r[1:0])
				2'd0: begin
					exp_exc = rv_decode_pkg::EXCEPT_INSTR_FAULT;
					drive(instr, 2'd2, r[2] ? 2'b01 : 2'b10, 1'b0, 1'b0, 32'h0);
				end
				2'd1: begin
					exp_exc    = rv_decode_pkg::EXCEPT_INSTR_ILLEGAL;
					instr[6:2] = (r[3:2] == 2'd0) ? 5'b00010 : (r[3:2] == 2'd1) ? 5'b00111 :
						(r[3:2] == 2'd2) ? 5'b01010 : 5'b11100;
					drive(instr, 2'd2, 2'd0, 1'b0, 1'b0, 32'h0);
				end
				default: begin
					exp_exc = rv_decode_pkg::EXCEPT_NONE;
					drive(instr, {1'b0, r[2]}, 2'd0, 1'b0, 1'b0, 32'h0);
				end
			endcase
			check_eq("d_except_o", 32'(d_except_o), 32'(exp_exc));
			check_eq("d_rs1_o", 32'(d_rs1_o), 32'd0);
			check_eq("d_rs2_o", 32'(d_rs2_o), 32'd0);
			check_eq("d_rd_o", 32'(d_rd_o), 32'd0);
			step();
		end

		// Mixed stalled and starved cycles against the PC model
		for (int i = 0; i < 80; i++) begin
			r = next_random();
			drive(32'h0000_0013, (r[4:2] == 3'd0) ? {1'b0, r[5]} : 2'd2, 2'd0,
				r[0] & r[1], 1'b0, 32'h0);
			step();
		end

		// Taken jump while execute stalls, then release
		for (int i = 0; i < 4; i++) begin
			r            = next_random();
			target       = next_random() & 32'hffff_fffc;
			instr        = next_random();
			instr[14:12] = 3'd0;
			instr[6:0]   = 7'h63;
			drive(instr, 2'd2, 2'd0, 1'b1, 1'b1, target);
			check_eq("df_cir_lock_o", 32'(df_cir_lock_o), 32'd1);
			step();
			hold = int'(r[1:0]) + 1;
			for (int k = 0; k < hold; k++) begin
				drive(instr, 2'd2, 2'd0, 1'b1, 1'b0, target);
				check_eq("d_branchcond_o", 32'(d_branchcond_o), 32'(rv_decode_pkg::BCOND_NEVER));
				step();
			end
			drive(instr, 2'd2, 2'd0, 1'b0, 1'b0, target);
			step();
			check_eq("d_pc_o", d_pc_o, target);
		end

		$display("checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: design/rv_decode.sv
// Decode stage for 32-bit-only RV32I; fetch must present both CIR halfwords before an instruction is consumed
module rv_decode (
	input  logic                                 clk,
	input  logic                                 rst_n,

	// Fetch interface
	input  logic [31:0]                          fd_cir_i,
	input  logic [1:0]                           fd_cir_vld_i,
	input  logic [1:0]                           fd_cir_err_i,
	output logic [1:0]                           df_cir_use_o,
	output logic                                 df_cir_lock_o,

	// Jump and stall control
	input  logic                                 x_stall_i,
	input  logic                                 f_jump_now_i,
	input  logic [rv_decode_pkg::XLEN-1:0]       f_jump_target_i,
	input  logic                                 x_jump_not_except_i,

	// Controls towards execute
	output logic [rv_decode_pkg::XLEN-1:0]       d_pc_o,
	output logic                                 d_starved_o,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] d_rs1_o,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] d_rs2_o,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] d_rd_o,
	output logic [rv_decode_pkg::XLEN-1:0]       d_imm_o,
	output rv_decode_pkg::alusrc_a_t             d_alusrc_a_o,
	output rv_decode_pkg::alusrc_b_t             d_alusrc_b_o,
	output rv_decode_pkg::aluop_t                d_aluop_o,
	output rv_decode_pkg::memop_t                d_memop_o,
	output rv_decode_pkg::bcond_t                d_branchcond_o,
	output logic                                 d_addr_is_regoffs_o,
	output rv_decode_pkg::except_t               d_except_o,
	output logic [rv_decode_pkg::XLEN-1:0]       d_addr_offs_o
);

	logic                           lock_prev;
	logic [rv_decode_pkg::XLEN-1:0] imm_i;
	logic [rv_decode_pkg::XLEN-1:0] imm_s;
	logic [rv_decode_pkg::XLEN-1:0] imm_b;
	logic [rv_decode_pkg::XLEN-1:0] imm_u;
	logic [rv_decode_pkg::XLEN-1:0] imm_j;

	rv_pc_cir_ctrl u_pc_cir_ctrl (
		.clk                 (clk),
		.rst_n               (rst_n),
		.fd_cir_vld_i        (fd_cir_vld_i),
		.x_stall_i           (x_stall_i),
		.f_jump_now_i        (f_jump_now_i),
		.f_jump_target_i     (f_jump_target_i),
		.x_jump_not_except_i (x_jump_not_except_i),
		.starved_o           (d_starved_o),
		.cir_use_o           (df_cir_use_o),
		.cir_lock_o          (df_cir_lock_o),
		.lock_prev_o         (lock_prev),
		.pc_o                (d_pc_o)
	);

	rv_imm_gen u_imm_gen (
		.instr_i     (fd_cir_i),
		.imm_i_o     (imm_i),
		.imm_s_o     (imm_s),
		.imm_b_o     (imm_b),
		.imm_u_o     (imm_u),
		.imm_j_o     (imm_j),
		.addr_offs_o (d_addr_offs_o)
	);

	rv_instr_decode u_instr_decode (
		.instr_i           (fd_cir_i),
		.fd_cir_vld_i      (fd_cir_vld_i),
		.fd_cir_err_i      (fd_cir_err_i),
		.starved_i         (d_starved_o),
		.lock_prev_i       (lock_prev),
		.imm_i_i           (imm_i),
		.imm_s_i           (imm_s),
		.imm_b_i           (imm_b),
		.imm_u_i           (imm_u),
		.imm_j_i           (imm_j),
		.rs1_o             (d_rs1_o),
		.rs2_o             (d_rs2_o),
		.rd_o              (d_rd_o),
		.imm_o             (d_imm_o),
		.alusrc_a_o        (d_alusrc_a_o),
		.alusrc_b_o        (d_alusrc_b_o),
		.aluop_o           (d_aluop_o),
		.memop_o           (d_memop_o),
		.branchcond_o      (d_branchcond_o),
		.addr_is_regoffs_o (d_addr_is_regoffs_o),
		.except_o          (d_except_o)
	);

endmodule

// File: design/rv_instr_decode.sv
// RV32I base set only; anything outside it, including 16-bit encodings, decodes as illegal
module rv_instr_decode (
	input  logic [31:0]                          instr_i,
	input  logic [1:0]                           fd_cir_vld_i,
	input  logic [1:0]                           fd_cir_err_i,
	input  logic                                 starved_i,
	input  logic                                 lock_prev_i,
	input  logic [rv_decode_pkg::XLEN-1:0]       imm_i_i,
	input  logic [rv_decode_pkg::XLEN-1:0]       imm_s_i,
	input  logic [rv_decode_pkg::XLEN-1:0]       imm_b_i,
	input  logic [rv_decode_pkg::XLEN-1:0]       imm_u_i,
	input  logic [rv_decode_pkg::XLEN-1:0]       imm_j_i,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_o,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_o,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_o,
	output logic [rv_decode_pkg::XLEN-1:0]       imm_o,
	output rv_decode_pkg::alusrc_a_t             alusrc_a_o,
	output rv_decode_pkg::alusrc_b_t             alusrc_b_o,
	output rv_decode_pkg::aluop_t                aluop_o,
	output rv_decode_pkg::memop_t                memop_o,
	output rv_decode_pkg::bcond_t                branchcond_o,
	output logic                                 addr_is_regoffs_o,
	output rv_decode_pkg::except_t               except_o
);

	logic [4:0]                     opc;
	logic [2:0]                     funct3;
	logic                           f7_zero;
	logic                           f7_alt;
	logic                           bus_fault;
	logic                           bad_enc;
	logic                           invalid;
	logic [rv_decode_pkg::XLEN-1:0] fmt_imm;

	// Shared by register and immediate ALU ops, alt picks SUB or SRA
	function automatic rv_decode_pkg::aluop_t alu_from_f3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? rv_decode_pkg::ALUOP_SUB : rv_decode_pkg::ALUOP_ADD;
			3'b001:  return rv_decode_pkg::ALUOP_SLL;
			3'b010:  return rv_decode_pkg::ALUOP_LT;
			3'b011:  return rv_decode_pkg::ALUOP_LTU;
			3'b100:  return rv_decode_pkg::ALUOP_XOR;
			3'b101:  return alt ? rv_decode_pkg::ALUOP_SRA : rv_decode_pkg::ALUOP_SRL;
			3'b110:  return rv_decode_pkg::ALUOP_OR;
			default: return rv_decode_pkg::ALUOP_AND;
		endcase
	endfunction

	assign opc     = instr_i[6:2];
	assign funct3  = instr_i[14:12];
	assign f7_zero = instr_i[31:25] == 7'h00;
	assign f7_alt  = instr_i[31:25] == 7'h20;

	// Fetch errors count only for halfwords that are actually valid
	assign bus_fault = (fd_cir_vld_i > 2'd0 && fd_cir_err_i[0]) ||
		(fd_cir_vld_i > 2'd1 && fd_cir_err_i[1]);

	assign invalid = bad_enc || instr_i[1:0] != 2'b11;

	// ------------------------------------------------------------------
	// Immediate of the instruction format
	// ------------------------------------------------------------------

	// Jumps replace this with the link step further down
	always_comb begin
		case (opc)
			rv_decode_pkg::OPC_STORE:  fmt_imm = imm_s_i;
			rv_decode_pkg::OPC_BRANCH: fmt_imm = imm_b_i;
			rv_decode_pkg::OPC_LUI:    fmt_imm = imm_u_i;
			rv_decode_pkg::OPC_AUIPC:  fmt_imm = imm_u_i;
			rv_decode_pkg::OPC_JAL:    fmt_imm = imm_j_i;
			default:                   fmt_imm = imm_i_i;
		endcase
	end

	// ------------------------------------------------------------------
	// Execute controls
	// ------------------------------------------------------------------

	always_comb begin
		rs1_o             = instr_i[19:15];
		rs2_o             = instr_i[24:20];
		rd_o              = instr_i[11:7];
		imm_o             = fmt_imm;
		alusrc_a_o        = rv_decode_pkg::ALUSRCA_RS1;
		alusrc_b_o        = rv_decode_pkg::ALUSRCB_RS2;
		aluop_o           = rv_decode_pkg::ALUOP_ADD;
		memop_o           = rv_decode_pkg::MEMOP_NONE;
		branchcond_o      = rv_decode_pkg::BCOND_NEVER;
		addr_is_regoffs_o = 1'b0;
		except_o          = rv_decode_pkg::EXCEPT_NONE;
		bad_enc           = 1'b0;

		case (opc)
			rv_decode_pkg::OPC_OP: begin
				aluop_o = alu_from_f3(funct3, f7_alt);
				bad_enc = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			rv_decode_pkg::OPC_OP_IMM: begin
				rs2_o      = '0;
				alusrc_b_o = rv_decode_pkg::ALUSRCB_IMM;
				aluop_o    = alu_from_f3(funct3, funct3 == 3'b101 && f7_alt);
				// Shift amounts leave only funct7 in the upper bits
				bad_enc    = funct3[1:0] == 2'b01 && !(f7_zero || (f7_alt && funct3[2]));
			end
			rv_decode_pkg::OPC_LUI: begin
				rs1_o      = '0;
				rs2_o      = '0;
				alusrc_b_o = rv_decode_pkg::ALUSRCB_IMM;
				aluop_o    = rv_decode_pkg::ALUOP_RS2;
			end
			rv_decode_pkg::OPC_AUIPC: begin
				rs1_o      = '0;
				rs2_o      = '0;
				alusrc_a_o = rv_decode_pkg::ALUSRCA_PC;
				alusrc_b_o = rv_decode_pkg::ALUSRCB_IMM;
			end
			rv_decode_pkg::OPC_LOAD: begin
				rs2_o             = '0;
				addr_is_regoffs_o = 1'b1;
				case (funct3)
					3'b000:  memop_o = rv_decode_pkg::MEMOP_LB;
					3'b001:  memop_o = rv_decode_pkg::MEMOP_LH;
					3'b010:  memop_o = rv_decode_pkg::MEMOP_LW;
					3'b100:  memop_o = rv_decode_pkg::MEMOP_LBU;
					3'b101:  memop_o = rv_decode_pkg::MEMOP_LHU;
					default: bad_enc = 1'b1;
				endcase
			end
			rv_decode_pkg::OPC_STORE: begin
				rd_o              = '0;
				aluop_o           = rv_decode_pkg::ALUOP_RS2;
				addr_is_regoffs_o = 1'b1;
				case (funct3)
					3'b000:  memop_o = rv_decode_pkg::MEMOP_SB;
					3'b001:  memop_o = rv_decode_pkg::MEMOP_SH;
					3'b010:  memop_o = rv_decode_pkg::MEMOP_SW;
					default: bad_enc = 1'b1;
				endcase
			end
			rv_decode_pkg::OPC_BRANCH: begin
				rd_o = '0;
				// BNE, BLT and BLTU take the branch on a nonzero result
				branchcond_o = (funct3[0] ^ funct3[2]) ? rv_decode_pkg::BCOND_NZERO :
					rv_decode_pkg::BCOND_ZERO;
				case (funct3[2:1])
					2'b00:   aluop_o = rv_decode_pkg::ALUOP_SUB;
					2'b10:   aluop_o = rv_decode_pkg::ALUOP_LT;
					2'b11:   aluop_o = rv_decode_pkg::ALUOP_LTU;
					default: bad_enc = 1'b1;
				endcase
			end
			rv_decode_pkg::OPC_JAL: begin
				rs1_o        = '0;
				rs2_o        = '0;
				imm_o        = rv_decode_pkg::INSTR_STEP;
				alusrc_a_o   = rv_decode_pkg::ALUSRCA_PC;
				alusrc_b_o   = rv_decode_pkg::ALUSRCB_IMM;
				branchcond_o = rv_decode_pkg::BCOND_ALWAYS;
			end
			rv_decode_pkg::OPC_JALR: begin
				rs2_o             = '0;
				imm_o             = rv_decode_pkg::INSTR_STEP;
				alusrc_a_o        = rv_decode_pkg::ALUSRCA_PC;
				alusrc_b_o        = rv_decode_pkg::ALUSRCB_IMM;
				branchcond_o      = rv_decode_pkg::BCOND_ALWAYS;
				addr_is_regoffs_o = 1'b1;
				bad_enc           = funct3 != 3'b000;
			end
			rv_decode_pkg::OPC_MISC_MEM: begin
				// FENCE is a no-op on this core, FENCE.I is not supported
				rs2_o   = '0;
				bad_enc = funct3 != 3'b000;
			end
			default: begin
				bad_enc = 1'b1;
			end
		endcase

		// Squash the slot so it has no side effects in execute
		if (invalid || starved_i || bus_fault) begin
			rs1_o        = '0;
			rs2_o        = '0;
			rd_o         = '0;
			memop_o      = rv_decode_pkg::MEMOP_NONE;
			branchcond_o = rv_decode_pkg::BCOND_NEVER;
			aluop_o      = rv_decode_pkg::ALUOP_ADD;
			except_o     = rv_decode_pkg::EXCEPT_NONE;
			if (bus_fault) begin
				except_o = rv_decode_pkg::EXCEPT_INSTR_FAULT;
			end else if (!starved_i) begin
				except_o = rv_decode_pkg::EXCEPT_INSTR_ILLEGAL;
			end
		end

		// The locked jump has already been issued once
		if (lock_prev_i) begin
			branchcond_o = rv_decode_pkg::BCOND_NEVER;
		end
	end

endmodule

// File: design/rv_pc_cir_ctrl.sv
// Assumes fetch honours the lock and keeps the target stable while a locked jump waits for the stall to clear
module rv_pc_cir_ctrl (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [1:0]                     fd_cir_vld_i,
	input  logic                           x_stall_i,
	input  logic                           f_jump_now_i,
	input  logic [rv_decode_pkg::XLEN-1:0] f_jump_target_i,
	input  logic                           x_jump_not_except_i,
	output logic                           starved_o,
	output logic [1:0]                     cir_use_o,
	output logic                           cir_lock_o,
	output logic                           lock_prev_o,
	output logic [rv_decode_pkg::XLEN-1:0] pc_o
);

	logic                           d_stall;
	logic                           assert_lock;
	logic                           release_lock;
	logic                           lock_prev_q;
	logic [rv_decode_pkg::XLEN-1:0] pc_q;

	// ------------------------------------------------------------------
	// Stall and consumption
	// ------------------------------------------------------------------

	// Every instruction needs both halfwords
	assign starved_o = fd_cir_vld_i < 2'd2;
	assign d_stall   = x_stall_i || starved_o;
	assign cir_use_o = d_stall ? 2'd0 : 2'd2;

	// ------------------------------------------------------------------
	// CIR lock
	// ------------------------------------------------------------------

	// A jump from this instruction while stalled must keep the CIR,
	// or incoming fetch data would lose the link and other side effects
	assign assert_lock  = f_jump_now_i && x_jump_not_except_i && d_stall;
	assign release_lock = !d_stall;
	assign cir_lock_o   = (lock_prev_q && !release_lock) || assert_lock;
	assign lock_prev_o  = lock_prev_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_prev_q <= 1'b0;
		end else begin
			lock_prev_q <= cir_lock_o;
		end
	end

	// ------------------------------------------------------------------
	// Program counter
	// ------------------------------------------------------------------

	// A held lock releasing reuses the target mux, the jump is still pending
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= rv_decode_pkg::RESET_VECTOR;
		end else if ((f_jump_now_i && !assert_lock) || (lock_prev_q && release_lock)) begin
			pc_q <= f_jump_target_i;
		end else if (!d_stall && !cir_lock_o) begin
			pc_q <= pc_q + rv_decode_pkg::INSTR_STEP;
		end
	end

	assign pc_o = pc_q;

endmodule

// File: design/rv_imm_gen.sv
// Immediates are valid only for 32-bit encodings; the address offset is zero for non-memory, non-jump opcodes
module rv_imm_gen (
	input  logic [31:0]                    instr_i,
	output logic [rv_decode_pkg::XLEN-1:0] imm_i_o,
	output logic [rv_decode_pkg::XLEN-1:0] imm_s_o,
	output logic [rv_decode_pkg::XLEN-1:0] imm_b_o,
	output logic [rv_decode_pkg::XLEN-1:0] imm_u_o,
	output logic [rv_decode_pkg::XLEN-1:0] imm_j_o,
	output logic [rv_decode_pkg::XLEN-1:0] addr_offs_o
);

	// All formats take their sign from bit 31
	assign imm_i_o = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s_o = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u_o = {instr_i[31:12], 12'h000};
	assign imm_j_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// Offset added to PC or rs1 by the address adder
	always_comb begin
		case (instr_i[6:2])
			rv_decode_pkg::OPC_JAL:    addr_offs_o = imm_j_o;
			rv_decode_pkg::OPC_BRANCH: addr_offs_o = imm_b_o;
			rv_decode_pkg::OPC_STORE:  addr_offs_o = imm_s_o;
			rv_decode_pkg::OPC_JALR:   addr_offs_o = imm_i_o;
			rv_decode_pkg::OPC_LOAD:   addr_offs_o = imm_i_o;
			default:                   addr_offs_o = '0;
		endcase
	end

endmodule

// File: design/rv_decode_pkg.sv
// RV32I only; compressed, CSR and extension encodings are not decoded here and count as illegal
package rv_decode_pkg;

	// ------------------------------------------------------------------
	// Widths and PC constants
	// ------------------------------------------------------------------

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0080;

	// No 16-bit instructions, so the PC always moves by a full word
	localparam logic [XLEN-1:0] INSTR_STEP = 32'h0000_0004;

	// ------------------------------------------------------------------
	// Major opcodes, instruction bits 6:2
	// ------------------------------------------------------------------

	localparam logic [4:0] OPC_LOAD     = 5'b00000;
	localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
	localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
	localparam logic [4:0] OPC_AUIPC    = 5'b00101;
	localparam logic [4:0] OPC_STORE    = 5'b01000;
	localparam logic [4:0] OPC_OP       = 5'b01100;
	localparam logic [4:0] OPC_LUI      = 5'b01101;
	localparam logic [4:0] OPC_BRANCH   = 5'b11000;
	localparam logic [4:0] OPC_JALR     = 5'b11001;
	localparam logic [4:0] OPC_JAL      = 5'b11011;

	// ------------------------------------------------------------------
	// Execute controls
	// ------------------------------------------------------------------

	// Gaps in the ALU encoding belong to operations this core lacks
	typedef enum logic [3:0] {
		ALUOP_ADD = 4'h0,
		ALUOP_SUB = 4'h1,
		ALUOP_LT  = 4'h2,
		ALUOP_LTU = 4'h4,
		ALUOP_AND = 4'h6,
		ALUOP_OR  = 4'h7,
		ALUOP_XOR = 4'h8,
		ALUOP_SRL = 4'h9,
		ALUOP_SRA = 4'ha,
		ALUOP_SLL = 4'hb,
		ALUOP_RS2 = 4'hd
	} aluop_t;

	typedef enum logic {
		ALUSRCA_RS1 = 1'b0,
		ALUSRCA_PC  = 1'b1
	} alusrc_a_t;

	typedef enum logic {
		ALUSRCB_RS2 = 1'b0,
		ALUSRCB_IMM = 1'b1
	} alusrc_b_t;

	// Loads first, then stores, with NONE parked at the top
	typedef enum logic [3:0] {
		MEMOP_LW   = 4'h0,
		MEMOP_LH   = 4'h1,
		MEMOP_LB   = 4'h2,
		MEMOP_LHU  = 4'h3,
		MEMOP_LBU  = 4'h4,
		MEMOP_SW   = 4'h5,
		MEMOP_SH   = 4'h6,
		MEMOP_SB   = 4'h7,
		MEMOP_NONE = 4'hf
	} memop_t;

	// Condition on the ALU result that makes execute take the jump
	typedef enum logic [1:0] {
		BCOND_NEVER  = 2'h0,
		BCOND_ALWAYS = 2'h1,
		BCOND_ZERO   = 2'h2,
		BCOND_NZERO  = 2'h3
	} bcond_t;

	typedef enum logic [1:0] {
		EXCEPT_NONE          = 2'h0,
		EXCEPT_INSTR_FAULT   = 2'h1,
		EXCEPT_INSTR_ILLEGAL = 2'h2
	} except_t;

endpackage
